// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --assert --timing -j 0
TOP       = s16_game_tb
FILELIST  = list.f

SIM_BIN   = obj_dir/V$(TOP)
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --assert --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir

// ==== hw/s16_cen.sv ====
// *********************************************************************
// Pixel enables from a 48 MHz clk. First pxl_cen on the 8th clock
// *********************************************************************
`timescale 1ns/1ps

module s16_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Free-running divider
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= 3'd0;
        end else begin
            cnt <= cnt + 3'd1;
        end
    end

    // 12 MHz and 6 MHz strobes land on the same terminal count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            pxl2_cen <= cnt[1:0] == 2'b11;
            pxl_cen  <= cnt == 3'b111;
        end
    end

endmodule

// ==== hw/s16_dwnld.sv ====
// *********************************************************************
// Packs loader bytes into 68000-order words. Holds a single word, so
// the loader must not finish another one while prog_we is high
// *********************************************************************
`timescale 1ns/1ps

module s16_dwnld #(
    parameter s16_pkg::ioctl_addr_t PAL_START = 25'h100000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 downloading,
    input  logic                 ioctl_wr,
    input  s16_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]           ioctl_data,
    input  logic                 prog_ack,
    output s16_pkg::prog_addr_t  prog_addr,
    output s16_pkg::word_t       prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 dwnld_busy,
    output logic                 pal_we,
    output s16_pkg::pal_addr_t   pal_addr,
    output s16_pkg::word_t       pal_data
);
    import s16_pkg::*;

    dl_state_t  state;
    logic [7:0] hi_byte;
    logic       odd_wr;
    logic       pal_hit;
    pal_addr_t  pal_idx;

    assign odd_wr  = ioctl_wr && ioctl_addr[0];
    assign pal_hit = ioctl_addr >= PAL_START;
    // Word index above PAL_START wraps at 32 entries
    assign pal_idx = ioctl_addr[PAL_AW:1] - PAL_START[PAL_AW:1];

    // Full words only
    assign prog_mask  = 2'b00;
    assign dwnld_busy = state != DL_IDLE;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= DL_IDLE;
            prog_we <= 1'b0;
            pal_we  <= 1'b0;
        end else begin
            pal_we <= 1'b0;
            case (state)
                DL_IDLE: begin
                    if (downloading) begin
                        state <= DL_LOAD;
                    end
                end
                DL_LOAD: begin
                    if (odd_wr) begin
                        if (pal_hit) begin
                            pal_we <= 1'b1;
                        end else begin
                            prog_we <= 1'b1;
                            state   <= DL_WAIT_ACK;
                        end
                    end else if (!downloading) begin
                        state <= DL_IDLE;
                    end
                end
                DL_WAIT_ACK: begin
                    // Drop the request on the clock after the ack
                    if (prog_ack) begin
                        prog_we <= 1'b0;
                        state   <= DL_LOAD;
                    end
                end
                default: state <= DL_IDLE;
            endcase
        end
    end

    // Word assembly. Even byte is the high half
    always_ff @(posedge clk) begin
        if (ioctl_wr && !ioctl_addr[0]) begin
            hi_byte <= ioctl_data;
        end
        if (odd_wr && state == DL_LOAD) begin
            if (pal_hit) begin
                pal_addr <= pal_idx;
                pal_data <= {hi_byte, ioctl_data};
            end else begin
                prog_addr <= ioctl_addr[22:1];
                prog_data <= {hi_byte, ioctl_data};
            end
        end
    end

endmodule

// ==== hw/s16_game.sv ====
// *********************************************************************
// Test-raster core top. No CPUs, no sound, no SDRAM bank controller
// *********************************************************************
`timescale 1ns/1ps

module s16_game #(
    parameter int                   H_TOTAL   = 384,
    parameter int                   H_ACTIVE  = 320,
    parameter int                   HS_START  = 336,
    parameter int                   HS_LEN    = 32,
    parameter int                   V_TOTAL   = 262,
    parameter int                   V_ACTIVE  = 224,
    parameter int                   VS_START  = 236,
    parameter int                   VS_LEN    = 3,
    parameter s16_pkg::ioctl_addr_t PAL_START = 25'h100000
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 pxl2_cen,   // 12 MHz
    output logic                 pxl_cen,    // 6 MHz
    output s16_pkg::rgb_t        red,
    output s16_pkg::rgb_t        green,
    output s16_pkg::rgb_t        blue,
    output logic                 LHBL_dly,
    output logic                 LVBL_dly,
    output logic                 HS,
    output logic                 VS,
    // ROM load
    input  logic                 downloading,
    output logic                 dwnld_busy,
    input  logic                 ioctl_wr,
    input  s16_pkg::ioctl_addr_t ioctl_addr,
    input  logic [7:0]           ioctl_data,
    output s16_pkg::prog_addr_t  prog_addr,
    output s16_pkg::word_t       prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    input  logic                 prog_ack
);
    import s16_pkg::*;

    pos_t      hdump;
    logic      LHBL;
    logic      LVBL;
    logic      pal_we;
    pal_addr_t pal_addr;
    word_t     pal_data;

    s16_cen u_cen (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    s16_vtimer #(
        .H_TOTAL  ( H_TOTAL  ),
        .H_ACTIVE ( H_ACTIVE ),
        .HS_START ( HS_START ),
        .HS_LEN   ( HS_LEN   ),
        .V_TOTAL  ( V_TOTAL  ),
        .V_ACTIVE ( V_ACTIVE ),
        .VS_START ( VS_START ),
        .VS_LEN   ( VS_LEN   )
    ) u_vtimer (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .hdump   ( hdump   ),
        .vdump   (         ),   // test raster only needs columns
        .LHBL    ( LHBL    ),
        .LVBL    ( LVBL    ),
        .HS      ( HS      ),
        .VS      ( VS      )
    );

    s16_dwnld #(
        .PAL_START ( PAL_START )
    ) u_dwnld (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog_ack    ( prog_ack    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .dwnld_busy  ( dwnld_busy  ),
        .pal_we      ( pal_we      ),
        .pal_addr    ( pal_addr    ),
        .pal_data    ( pal_data    )
    );

    s16_palette u_palette (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .hdump    ( hdump    ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .pal_we   ( pal_we   ),
        .pal_addr ( pal_addr ),
        .pal_data ( pal_data ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly )
    );

endmodule

// ==== hw/s16_palette.sv ====
// *********************************************************************
// 32-entry colour RAM indexed by hdump/8. Output is one pixel late,
// with blanking delayed to match. Entries are xRRRRRGGGGGBBBBB
// *********************************************************************
`timescale 1ns/1ps

module s16_palette (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pxl_cen,
    input  s16_pkg::pos_t      hdump,
    input  logic               LHBL,
    input  logic               LVBL,
    input  logic               pal_we,
    input  s16_pkg::pal_addr_t pal_addr,
    input  s16_pkg::word_t     pal_data,
    output s16_pkg::rgb_t      red,
    output s16_pkg::rgb_t      green,
    output s16_pkg::rgb_t      blue,
    output logic               LHBL_dly,
    output logic               LVBL_dly
);
    import s16_pkg::*;

    word_t pal_mem [0:PAL_SIZE-1];
    word_t entry;

    // Power-up contents are black
    initial begin
        for (int i = 0; i < PAL_SIZE; i++) begin
            pal_mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (pal_we) begin
            pal_mem[pal_addr] <= pal_data;
        end
    end

    // Eight-pixel columns
    assign entry = pal_mem[hdump[PAL_AW+2:3]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (pxl_cen) begin
            LHBL_dly <= LHBL;
            LVBL_dly <= LVBL;
            if (LHBL && LVBL) begin
                red   <= entry[14:10];
                green <= entry[9:5];
                blue  <= entry[4:0];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

// ==== hw/s16_pkg.sv ====
// *********************************************************************
// Shared types for the cut-down System 16 core. The palette is fixed
// at 32 entries of 15-bit colour and the loader bus is byte wide
// *********************************************************************
package s16_pkg;

    // One 5-bit colour channel
    typedef logic [4:0] rgb_t;

    // Raster position for both counters
    typedef logic [8:0] pos_t;

    // Loader byte address
    typedef logic [24:0] ioctl_addr_t;

    // SDRAM word address
    typedef logic [21:0] prog_addr_t;

    typedef logic [15:0] word_t;

    // Palette geometry
    localparam int PAL_AW   = 5;
    localparam int PAL_SIZE = 1 << PAL_AW;

    typedef logic [PAL_AW-1:0] pal_addr_t;

    // Download controller states
    typedef enum logic [1:0] {
        DL_IDLE,
        DL_LOAD,
        DL_WAIT_ACK
    } dl_state_t;

endpackage

// ==== hw/s16_vtimer.sv ====
// *********************************************************************
// Raster timer advanced by pxl_cen. Totals must fit in 9 bits and the
// last line and pixel must sit outside both sync pulses
// *********************************************************************
`timescale 1ns/1ps

module s16_vtimer #(
    parameter int H_TOTAL  = 384,
    parameter int H_ACTIVE = 320,
    parameter int HS_START = 336,
    parameter int HS_LEN   = 32,
    parameter int V_TOTAL  = 262,
    parameter int V_ACTIVE = 224,
    parameter int VS_START = 236,
    parameter int VS_LEN   = 3
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          pxl_cen,
    output s16_pkg::pos_t hdump,
    output s16_pkg::pos_t vdump,
    output logic          LHBL,
    output logic          LVBL,
    output logic          HS,
    output logic          VS
);
    import s16_pkg::*;

    pos_t h_next;
    pos_t v_next;

    // Next raster position
    always_comb begin
        h_next = hdump + pos_t'(1);
        v_next = vdump;
        if (hdump == pos_t'(H_TOTAL - 1)) begin
            h_next = '0;
            if (vdump == pos_t'(V_TOTAL - 1)) begin
                v_next = '0;
            end else begin
                v_next = vdump + pos_t'(1);
            end
        end
    end

    // Reset parks the beam on the last pixel so that all levels start low
    // and the first pxl_cen lands on 0,0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdump <= pos_t'(H_TOTAL - 1);
            vdump <= pos_t'(V_TOTAL - 1);
            LHBL  <= 1'b0;
            LVBL  <= 1'b0;
            HS    <= 1'b0;
            VS    <= 1'b0;
        end else if (pxl_cen) begin
            hdump <= h_next;
            vdump <= v_next;
            LHBL  <= h_next < pos_t'(H_ACTIVE);
            LVBL  <= v_next < pos_t'(V_ACTIVE);
            HS    <= (h_next >= pos_t'(HS_START)) &&
                     (h_next <  pos_t'(HS_START + HS_LEN));
            VS    <= (v_next >= pos_t'(VS_START)) &&
                     (v_next <  pos_t'(VS_START + VS_LEN));
        end
    end

endmodule

// ==== list.f ====
hw/s16_pkg.sv
hw/s16_cen.sv
hw/s16_vtimer.sv
hw/s16_dwnld.sv
hw/s16_palette.sv
hw/s16_game.sv
sim/s16_game_asserts.sv
sim/s16_game_tb.sv

// ==== sim/s16_game_asserts.sv ====
// **********************************************************************
// Prog port and clock enable protocol checks, bound into s16_game
// **********************************************************************
`timescale 1ns/1ps

module s16_game_asserts (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 pxl2_cen,
    input  logic                 pxl_cen,
    input  logic                 ioctl_wr,
    input  s16_pkg::ioctl_addr_t ioctl_addr,
    input  logic                 prog_we,
    input  logic                 prog_ack,
    input  s16_pkg::prog_addr_t  prog_addr,
    input  s16_pkg::word_t       prog_data,
    input  s16_pkg::dl_state_t   dl_state
);
    import s16_pkg::*;

    // The slow enable always lands on a fast one
    a_cen_pair: assert property (@(posedge clk) disable iff (!rst_n)
        pxl_cen |-> pxl2_cen) else $error("pxl_cen high without pxl2_cen");

    a_cen_single: assert property (@(posedge clk) disable iff (!rst_n)
        pxl2_cen |=> !pxl2_cen) else $error("pxl2_cen longer than one cycle");

    // An odd byte is lost unless the FSM has left idle
    a_load_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ioctl_wr && ioctl_addr[0] |-> dl_state != DL_IDLE)
        else $error("odd byte while download FSM idle");

    a_we_hold: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && !prog_ack |=> prog_we && $stable(prog_addr) && $stable(prog_data))
        else $error("prog port changed before prog_ack");

    a_we_drop: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we && prog_ack |=> !prog_we) else $error("prog_we still high after prog_ack");

    a_ack_req: assert property (@(posedge clk) disable iff (!rst_n)
        prog_ack |-> prog_we) else $error("prog_ack without a request");

    // Loader must not finish a word while one is pending
    a_one_word: assert property (@(posedge clk) disable iff (!rst_n)
        prog_we |-> !(ioctl_wr && ioctl_addr[0])) else $error("second word while prog_we high");

endmodule

// ==== sim/s16_game_tb.sv ====
// **********************************************************************
// Random ROM and palette download, then three frames of raster checks.
// Raster parameters are shrunk so a frame is short
// **********************************************************************
`timescale 1ns/1ps

module s16_game_tb;
    import s16_pkg::*;

    localparam int          CLK_PERIOD   = 20;
    localparam int          H_TOTAL      = 96;
    localparam int          H_ACTIVE     = 64;
    localparam int          HS_START     = 72;
    localparam int          HS_LEN       = 8;
    localparam int          V_TOTAL      = 40;
    localparam int          V_ACTIVE     = 24;
    localparam int          VS_START     = 30;
    localparam int          VS_LEN       = 2;
    localparam ioctl_addr_t PAL_START    = 25'h100000;
    localparam int          WORDS        = 32;
    localparam int          MAX_GAP      = 3;
    localparam int          MAX_ACK      = 4;
    localparam int          FRAME_CYCLES = V_TOTAL * H_TOTAL * 8;
    // Worst case per byte is gap, strobe, ack wait and the drop of prog_we
    localparam int          BYTE_CYCLES  = MAX_GAP + 1 + MAX_ACK + 2;
    localparam int          LIMIT_NS     =
        2 * (4 * WORDS * BYTE_CYCLES + 3 * FRAME_CYCLES) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic        ioctl_wr;
    ioctl_addr_t ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        prog_ack;
    logic        pxl2_cen;
    logic        pxl_cen;
    rgb_t        red;
    rgb_t        green;
    rgb_t        blue;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic        HS;
    logic        VS;
    logic        dwnld_busy;
    prog_addr_t  prog_addr;
    word_t       prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;

    // Reference model
    prog_addr_t exp_addr [$];
    word_t      exp_data [$];
    word_t      exp_pal  [0:PAL_SIZE-1];
    word_t      entry;
    logic       download_done = 1'b0;
    int         clk_cnt       = 0;
    int         words_seen    = 0;
    int         colour_checks = 0;
    int         frame_checks  = 0;

    // Raster trackers sampled on pxl_cen
    logic hs_prev   = 1'b0;
    logic vs_prev   = 1'b0;
    logic lhbl_prev = 1'b0;
    logic lvbl_prev = 1'b0;
    logic lhbl_rise;
    logic hs_seen   = 1'b0;
    int   hs_gap    = 0;
    int   hs_high   = 0;
    int   col       = 0;
    int   vis_lines = 0;
    int   vs_lines  = 0;
    logic dl_prev   = 1'b0;
    logic we_prev   = 1'b0;

    s16_game #(
        .H_TOTAL   ( H_TOTAL   ),
        .H_ACTIVE  ( H_ACTIVE  ),
        .HS_START  ( HS_START  ),
        .HS_LEN    ( HS_LEN    ),
        .V_TOTAL   ( V_TOTAL   ),
        .V_ACTIVE  ( V_ACTIVE  ),
        .VS_START  ( VS_START  ),
        .VS_LEN    ( VS_LEN    ),
        .PAL_START ( PAL_START )
    ) dut (.*);

    bind s16_game s16_game_asserts u_asserts (
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .pxl2_cen   ( pxl2_cen      ),
        .pxl_cen    ( pxl_cen       ),
        .ioctl_wr   ( ioctl_wr      ),
        .ioctl_addr ( ioctl_addr    ),
        .prog_we    ( prog_we       ),
        .prog_ack   ( prog_ack      ),
        .prog_addr  ( prog_addr     ),
        .prog_data  ( prog_data     ),
        .dl_state   ( u_dwnld.state )
    );

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error at %0d ns: %s expected %0h got %0h",
                 $time, name, expected, actual);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic abort_run(input string what);
        $display("%s at %0d ns", what, $time);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic send_byte(input ioctl_addr_t addr, input logic [7:0] data);
        int gap;
        gap = int'($urandom % (MAX_GAP + 1));
        repeat (gap) @(negedge clk);
        // Only one word may be in flight
        if (addr[0]) begin
            while (prog_we) @(negedge clk);
        end
        ioctl_wr   = 1'b1;
        ioctl_addr = addr;
        ioctl_data = data;
        @(negedge clk);
        ioctl_wr = 1'b0;
    endtask

    task automatic load_rom_and_palette;
        logic [7:0] hi;
        logic [7:0] lo;
        downloading = 1'b1;
        @(negedge clk);
        for (int w = 0; w < WORDS; w++) begin
            hi = 8'($urandom);
            lo = 8'($urandom);
            exp_addr.push_back(prog_addr_t'(w));
            exp_data.push_back({hi, lo});
            send_byte(ioctl_addr_t'(2 * w), hi);
            send_byte(ioctl_addr_t'(2 * w + 1), lo);
        end
        for (int w = 0; w < WORDS; w++) begin
            hi = 8'($urandom);
            lo = 8'($urandom);
            exp_pal[w] = {hi, lo};
            send_byte(PAL_START + ioctl_addr_t'(2 * w), hi);
            send_byte(PAL_START + ioctl_addr_t'(2 * w + 1), lo);
        end
        downloading = 1'b0;
        while (dwnld_busy) @(negedge clk);
        // Two pixels for the last palette write to reach the outputs
        repeat (16) @(negedge clk);
        download_done = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(LIMIT_NS);
        abort_run("timeout, download and three frames did not finish");
    end

    // SDRAM side answers each request after 1 to 4 cycles
    initial begin
        int delay;
        prog_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                delay = 1 + int'($urandom % MAX_ACK);
                repeat (delay - 1) @(negedge clk);
                prog_ack = 1'b1;
                @(negedge clk);
                prog_ack = 1'b0;
            end
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_cnt <= 0;
        end else begin
            clk_cnt <= clk_cnt + 1;
        end
    end

    // Clock enables, prog port and busy
    always @(posedge clk) begin
        if (rst_n) begin
            assert (pxl2_cen == (clk_cnt != 0 && clk_cnt % 4 == 0))
                else report_mismatch("pxl2_cen", 32'(!pxl2_cen), 32'(pxl2_cen));
            assert (pxl_cen == (clk_cnt != 0 && clk_cnt % 8 == 0))
                else report_mismatch("pxl_cen", 32'(!pxl_cen), 32'(pxl_cen));
            if (prog_we) begin
                assert (exp_addr.size() > 0)
                    else abort_run("prog_we raised with no ROM word pending");
                assert (prog_mask == 2'b00)
                    else report_mismatch("prog_mask", 0, 32'(prog_mask));
                assert (dwnld_busy) else report_mismatch("dwnld_busy", 1, 0);
            end
            if (prog_we && prog_ack) begin
                assert (prog_addr == exp_addr[0])
                    else report_mismatch("prog_addr", 32'(exp_addr[0]), 32'(prog_addr));
                assert (prog_data == exp_data[0])
                    else report_mismatch("prog_data", 32'(exp_data[0]), 32'(prog_data));
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                words_seen++;
            end
            if (downloading && dl_prev) begin
                assert (dwnld_busy) else report_mismatch("dwnld_busy", 1, 0);
            end
            if (!downloading && !dl_prev && !prog_we && !we_prev) begin
                assert (!dwnld_busy) else report_mismatch("dwnld_busy", 0, 1);
            end
            dl_prev = downloading;
            we_prev = prog_we;
        end
    end

    // Raster timing and pixel colour sampled once per pixel
    always @(posedge clk) begin
        if (rst_n && pxl_cen) begin
            if (HS && !hs_prev) begin
                if (hs_seen) begin
                    assert (hs_gap == H_TOTAL)
                        else report_mismatch("HS period", H_TOTAL, hs_gap);
                end
                hs_seen = 1'b1;
                hs_gap  = 1;
            end else begin
                hs_gap++;
            end
            if (HS) begin
                hs_high++;
            end else if (hs_prev) begin
                assert (hs_high == HS_LEN)
                    else report_mismatch("HS width", HS_LEN, hs_high);
                hs_high = 0;
            end
            if (LHBL_dly) begin
                col = lhbl_prev ? col + 1 : 0;
            end else if (lhbl_prev) begin
                assert (col + 1 == H_ACTIVE)
                    else report_mismatch("LHBL_dly width", H_ACTIVE, col + 1);
            end
            lhbl_rise = LHBL_dly && !lhbl_prev;
            if (!LVBL_dly && lvbl_prev) begin
                assert (vis_lines == V_ACTIVE)
                    else report_mismatch("LVBL_dly lines", V_ACTIVE, vis_lines);
                vis_lines = 0;
                frame_checks++;
            end
            if (lhbl_rise && LVBL_dly) begin
                vis_lines++;
            end
            if (!VS && vs_prev) begin
                assert (vs_lines == VS_LEN)
                    else report_mismatch("VS lines", VS_LEN, vs_lines);
                vs_lines = 0;
            end
            if (lhbl_rise && VS) begin
                vs_lines++;
            end
            if (LHBL_dly && LVBL_dly) begin
                if (download_done) begin
                    entry = exp_pal[(col / 8) % PAL_SIZE];
                    assert (red == entry[14:10])
                        else report_mismatch("red", 32'(entry[14:10]), 32'(red));
                    assert (green == entry[9:5])
                        else report_mismatch("green", 32'(entry[9:5]), 32'(green));
                    assert (blue == entry[4:0])
                        else report_mismatch("blue", 32'(entry[4:0]), 32'(blue));
                    colour_checks++;
                end
            end else begin
                assert ({red, green, blue} == 15'd0)
                    else report_mismatch("rgb in blanking", 0, 32'({red, green, blue}));
            end
            hs_prev   = HS;
            vs_prev   = VS;
            lhbl_prev = LHBL_dly;
            lvbl_prev = LVBL_dly;
        end
    end

    initial begin
        void'($urandom(32'he612646f));
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'h00;
        for (int i = 0; i < PAL_SIZE; i++) begin
            exp_pal[i] = '0;
        end
        repeat (4) @(negedge clk);
        assert (!prog_we && !dwnld_busy && !pxl2_cen && !pxl_cen && !HS && !VS)
            else abort_run("a control output is high during reset");
        rst_n = 1'b1;
        @(negedge clk);
        load_rom_and_palette();
        repeat (3 * FRAME_CYCLES) @(negedge clk);
        if (words_seen != WORDS) begin
            report_mismatch("ROM words written", WORDS, words_seen);
        end else if (colour_checks == 0 || frame_checks == 0) begin
            abort_run("no visible pixel or frame was checked");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
